/* ace_demux.f */
hw/ace_cfg_pkg.sv
hw/ace_chan_pkg.sv
hw/ace_req_router.sv
hw/ace_resp_arbiter.sv
hw/ace_ack_tracker.sv
hw/ace_demux.sv
sim/ace_demux_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module ace_demux_tb \
    -Mdir obj_dir \
    -f ace_demux.f

./obj_dir/Vace_demux_tb

/* sim/ace_demux_tb.sv */
`timescale 1ns/10ps

module ace_demux_tb;

    import ace_cfg_pkg::*;
    import ace_chan_pkg::*;

    localparam int ClkPeriod     = 40;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 200;

    typedef logic [NoMstPorts-1:0] port_vec_t;

    logic                        clk;
    logic                        rst_n;
    slv_req_t                    slv_req;
    port_idx_t                   wr_sel;
    port_idx_t                   ar_sel;
    slv_resp_t                   slv_resp;
    mst_req_t  [NoMstPorts-1:0]  mst_reqs;
    mst_resp_t [NoMstPorts-1:0]  mst_resps;

    // Per-port views of the downstream request bundles
    port_vec_t wr_vld;
    port_vec_t ar_vld;
    port_vec_t b_rdy;
    port_vec_t r_rdy;
    port_vec_t wack_vec;
    port_vec_t rack_vec;

    ace_demux u_ace_demux (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .slv_req_i       (slv_req),
        .slv_wr_select_i (wr_sel),
        .slv_ar_select_i (ar_sel),
        .slv_resp_o      (slv_resp),
        .mst_reqs_o      (mst_reqs),
        .mst_resps_i     (mst_resps)
    );

    for (genvar i = 0; i < NoMstPorts; i++) begin : g_port_view
        assign wr_vld[i]   = mst_reqs[i].wr_valid;
        assign ar_vld[i]   = mst_reqs[i].ar_valid;
        assign b_rdy[i]    = mst_reqs[i].b_ready;
        assign r_rdy[i]    = mst_reqs[i].r_ready;
        assign wack_vec[i] = mst_reqs[i].wack;
        assign rack_vec[i] = mst_reqs[i].rack;
    end

    always #(ClkPeriod / 2) clk = ~clk;

    initial begin
        #(NumTests * CyclesPerTest * ClkPeriod);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAILED");
        $fatal(1, "Simulation ran past its time limit");
    end

    task automatic expect_eq(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Value check failed");
        end
    endtask

    function automatic port_vec_t port_bit(input port_idx_t port);
        return port_vec_t'(1) << port;
    endfunction

    // One request, first held off by the port, then accepted
    task automatic send_req(input logic read, input port_idx_t port);
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data;
        addr = $urandom();
        data = $urandom();
        @(negedge clk);
        if (read) begin
            slv_req.ar_valid = 1'b1;
            slv_req.ar.addr  = addr;
            ar_sel           = port;
        end else begin
            slv_req.wr_valid = 1'b1;
            slv_req.wr.addr  = addr;
            slv_req.wr.data  = data;
            wr_sel           = port;
        end
        #1;
        expect_eq(read ? "mst ar_valid" : "mst wr_valid", 64'(port_bit(port)),
                  64'(read ? ar_vld : wr_vld));
        expect_eq("slv req ready", 64'(0),
                  64'(read ? slv_resp.ar_ready : slv_resp.wr_ready));
        @(negedge clk);
        mst_resps[port].ar_ready = read;
        mst_resps[port].wr_ready = !read;
        #1;
        expect_eq("slv req ready", 64'(1),
                  64'(read ? slv_resp.ar_ready : slv_resp.wr_ready));
        if (read) begin
            expect_eq("mst ar.addr", 64'(addr), 64'(mst_reqs[port].ar.addr));
        end else begin
            expect_eq("mst wr.addr", 64'(addr), 64'(mst_reqs[port].wr.addr));
            expect_eq("mst wr.data", 64'(data), 64'(mst_reqs[port].wr.data));
        end
        @(negedge clk);
        slv_req.wr_valid         = 1'b0;
        slv_req.ar_valid         = 1'b0;
        mst_resps[port].wr_ready = 1'b0;
        mst_resps[port].ar_ready = 1'b0;
    endtask

    task automatic return_b(input port_idx_t port);
        logic [1:0] resp;
        resp = 2'($urandom());
        @(negedge clk);
        mst_resps[port].b_valid = 1'b1;
        mst_resps[port].b.resp  = resp;
        #1;
        expect_eq("slv b_valid", 64'(1), 64'(slv_resp.b_valid));
        expect_eq("slv b.resp", 64'(resp), 64'(slv_resp.b.resp));
        expect_eq("mst b_ready", 64'(port_bit(port)), 64'(b_rdy));
        @(negedge clk);
        mst_resps[port].b_valid = 1'b0;
    endtask

    task automatic return_r(input port_idx_t port);
        logic [DataWidth-1:0] data;
        logic [1:0]           resp;
        data = $urandom();
        resp = 2'($urandom());
        @(negedge clk);
        mst_resps[port].r_valid = 1'b1;
        mst_resps[port].r.data  = data;
        mst_resps[port].r.resp  = resp;
        mst_resps[port].r.last  = 1'b1;
        #1;
        expect_eq("slv r_valid", 64'(1), 64'(slv_resp.r_valid));
        expect_eq("slv r.data", 64'(data), 64'(slv_resp.r.data));
        expect_eq("slv r.resp", 64'(resp), 64'(slv_resp.r.resp));
        expect_eq("slv r.last", 64'(1), 64'(slv_resp.r.last));
        expect_eq("mst r_ready", 64'(port_bit(port)), 64'(r_rdy));
        @(negedge clk);
        mst_resps[port].r_valid = 1'b0;
    endtask

    task automatic pulse_ack(input logic read, input port_idx_t port);
        @(negedge clk);
        slv_req.wack = !read;
        slv_req.rack = read;
        #1;
        expect_eq(read ? "mst rack" : "mst wack", 64'(port_bit(port)),
                  64'(read ? rack_vec : wack_vec));
        @(negedge clk);
        slv_req.wack = 1'b0;
        slv_req.rack = 1'b0;
    endtask

    task automatic write_and_respond(input port_idx_t port);
        send_req(1'b0, port);
        return_b(port);
        pulse_ack(1'b0, port);
    endtask

    // Present B on three ports at once with resp tagging each port
    task automatic b_round(input port_idx_t [2:0] order);
        @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            mst_resps[order[i]].b_valid = 1'b1;
            mst_resps[order[i]].b.resp  = order[i];
        end
        for (int i = 0; i < 3; i++) begin
            #1;
            expect_eq("slv b_valid", 64'(1), 64'(slv_resp.b_valid));
            expect_eq("slv b.resp", 64'(order[i]), 64'(slv_resp.b.resp));
            expect_eq("mst b_ready", 64'(port_bit(order[i])), 64'(b_rdy));
            @(negedge clk);
            mst_resps[order[i]].b_valid = 1'b0;
        end
    endtask

    task automatic write_routing();
        for (int p = 0; p < NoMstPorts; p++) begin
            write_and_respond(port_idx_t'(p));
        end
    endtask

    task automatic read_routing();
        for (int p = 0; p < NoMstPorts; p++) begin
            send_req(1'b1, port_idx_t'(p));
            return_r(port_idx_t'(p));
            pulse_ack(1'b1, port_idx_t'(p));
        end
    endtask

    task automatic ordering_stall();
        logic [AddrWidth-1:0] addr;
        logic [1:0]           resp;
        addr = $urandom();
        resp = 2'($urandom());
        send_req(1'b0, port_idx_t'(1));
        @(negedge clk);
        slv_req.wr_valid      = 1'b1;
        slv_req.wr.addr       = addr;
        wr_sel                = port_idx_t'(2);
        mst_resps[2].wr_ready = 1'b1;
        #1;
        expect_eq("slv wr_ready", 64'(0), 64'(slv_resp.wr_ready));
        expect_eq("mst wr_valid", 64'(0), 64'(wr_vld));
        // Port 1 answers while the write to port 2 waits
        @(negedge clk);
        mst_resps[1].b_valid = 1'b1;
        mst_resps[1].b.resp  = resp;
        #1;
        expect_eq("slv b_valid", 64'(1), 64'(slv_resp.b_valid));
        expect_eq("slv b.resp", 64'(resp), 64'(slv_resp.b.resp));
        expect_eq("slv wr_ready", 64'(0), 64'(slv_resp.wr_ready));
        expect_eq("mst wr_valid", 64'(0), 64'(wr_vld));
        @(negedge clk);
        mst_resps[1].b_valid = 1'b0;
        #1;
        expect_eq("mst wr_valid", 64'(port_bit(port_idx_t'(2))), 64'(wr_vld));
        expect_eq("slv wr_ready", 64'(1), 64'(slv_resp.wr_ready));
        expect_eq("mst wr.addr", 64'(addr), 64'(mst_reqs[2].wr.addr));
        @(negedge clk);
        slv_req.wr_valid      = 1'b0;
        mst_resps[2].wr_ready = 1'b0;
        return_b(port_idx_t'(2));
        pulse_ack(1'b0, port_idx_t'(1));
        pulse_ack(1'b0, port_idx_t'(2));
    endtask

    task automatic round_robin();
        // A B from port 3 leaves the pointer at port 0
        write_and_respond(port_idx_t'(3));
        repeat (3) send_req(1'b0, port_idx_t'(0));
        b_round({port_idx_t'(3), port_idx_t'(2), port_idx_t'(0)});
        pulse_ack(1'b0, port_idx_t'(0));
        pulse_ack(1'b0, port_idx_t'(2));
        pulse_ack(1'b0, port_idx_t'(3));
        // Pointer moves past port 1, so port 2 wins first
        write_and_respond(port_idx_t'(1));
        repeat (3) send_req(1'b0, port_idx_t'(0));
        b_round({port_idx_t'(0), port_idx_t'(3), port_idx_t'(2)});
        pulse_ack(1'b0, port_idx_t'(2));
        pulse_ack(1'b0, port_idx_t'(3));
        pulse_ack(1'b0, port_idx_t'(0));
    endtask

    task automatic ack_steering();
        repeat (3) send_req(1'b0, port_idx_t'(0));
        return_b(port_idx_t'(3));
        return_b(port_idx_t'(1));
        return_b(port_idx_t'(0));
        pulse_ack(1'b0, port_idx_t'(3));
        pulse_ack(1'b0, port_idx_t'(1));
        pulse_ack(1'b0, port_idx_t'(0));
        repeat (3) send_req(1'b1, port_idx_t'(0));
        return_r(port_idx_t'(3));
        return_r(port_idx_t'(1));
        return_r(port_idx_t'(0));
        pulse_ack(1'b1, port_idx_t'(3));
        pulse_ack(1'b1, port_idx_t'(1));
        pulse_ack(1'b1, port_idx_t'(0));
    endtask

    task automatic tracker_full();
        logic [1:0] resp;
        resp = 2'($urandom());
        repeat (MaxTrans) send_req(1'b0, port_idx_t'(0));
        repeat (MaxTrans) return_b(port_idx_t'(2));
        send_req(1'b0, port_idx_t'(0));
        @(negedge clk);
        mst_resps[1].b_valid = 1'b1;
        mst_resps[1].b.resp  = resp;
        #1;
        expect_eq("slv b_valid", 64'(0), 64'(slv_resp.b_valid));
        expect_eq("mst b_ready", 64'(0), 64'(b_rdy));
        @(negedge clk);
        slv_req.wack = 1'b1;
        #1;
        expect_eq("mst wack", 64'(port_bit(port_idx_t'(2))), 64'(wack_vec));
        expect_eq("slv b_valid", 64'(0), 64'(slv_resp.b_valid));
        @(negedge clk);
        slv_req.wack = 1'b0;
        #1;
        expect_eq("slv b_valid", 64'(1), 64'(slv_resp.b_valid));
        expect_eq("slv b.resp", 64'(resp), 64'(slv_resp.b.resp));
        expect_eq("mst b_ready", 64'(port_bit(port_idx_t'(1))), 64'(b_rdy));
        @(negedge clk);
        mst_resps[1].b_valid = 1'b0;
        repeat (MaxTrans - 1) pulse_ack(1'b0, port_idx_t'(2));
        pulse_ack(1'b0, port_idx_t'(1));
    endtask

    initial begin
        void'($urandom(32'ha70b_a353));
        clk       = 1'b0;
        rst_n     = 1'b0;
        slv_req   = '0;
        wr_sel    = '0;
        ar_sel    = '0;
        mst_resps = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n           = 1'b1;
        slv_req.b_ready = 1'b1;
        slv_req.r_ready = 1'b1;

        write_routing();
        read_routing();
        ordering_stall();
        round_robin();
        ack_steering();
        tracker_full();

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* hw/ace_demux.sv */
`timescale 1ns/10ps

module ace_demux (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  ace_chan_pkg::slv_req_t                              slv_req_i,
    input  ace_cfg_pkg::port_idx_t                              slv_wr_select_i,
    input  ace_cfg_pkg::port_idx_t                              slv_ar_select_i,
    output ace_chan_pkg::slv_resp_t                             slv_resp_o,
    output ace_chan_pkg::mst_req_t  [ace_cfg_pkg::NoMstPorts-1:0] mst_reqs_o,
    input  ace_chan_pkg::mst_resp_t [ace_cfg_pkg::NoMstPorts-1:0] mst_resps_i
);

    import ace_cfg_pkg::*;
    import ace_chan_pkg::*;

    logic    [NoMstPorts-1:0] mst_wr_valid;
    logic    [NoMstPorts-1:0] mst_ar_valid;
    logic    [NoMstPorts-1:0] mst_wr_ready;
    logic    [NoMstPorts-1:0] mst_ar_ready;
    logic                     wr_ready;
    logic                     ar_ready;

    logic    [NoMstPorts-1:0] b_valid_in;
    logic    [NoMstPorts-1:0] r_valid_in;
    b_chan_t [NoMstPorts-1:0] b_in;
    r_chan_t [NoMstPorts-1:0] r_in;
    logic    [NoMstPorts-1:0] b_ready_out;
    logic    [NoMstPorts-1:0] r_ready_out;

    logic                     b_valid_arb;
    logic                     r_valid_arb;
    b_chan_t                  b_arb;
    r_chan_t                  r_arb;
    logic                     b_ready_arb;
    logic                     r_ready_arb;
    port_idx_t                b_idx;
    port_idx_t                r_idx;

    logic                     b_full;
    logic                     r_full;
    logic                     b_done;
    logic                     r_done;
    logic    [NoMstPorts-1:0] wack;
    logic    [NoMstPorts-1:0] rack;

    for (genvar i = 0; i < NoMstPorts; i++) begin : g_resp_in
        assign mst_wr_ready[i] = mst_resps_i[i].wr_ready;
        assign mst_ar_ready[i] = mst_resps_i[i].ar_ready;
        assign b_valid_in[i]   = mst_resps_i[i].b_valid;
        assign b_in[i]         = mst_resps_i[i].b;
        assign r_valid_in[i]   = mst_resps_i[i].r_valid;
        assign r_in[i]         = mst_resps_i[i].r;
    end

    ace_req_router u_req_router (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wr_valid_i     (slv_req_i.wr_valid),
        .wr_select_i    (slv_wr_select_i),
        .ar_valid_i     (slv_req_i.ar_valid),
        .ar_select_i    (slv_ar_select_i),
        .wr_ready_o     (wr_ready),
        .ar_ready_o     (ar_ready),
        .mst_wr_valid_o (mst_wr_valid),
        .mst_ar_valid_o (mst_ar_valid),
        .mst_wr_ready_i (mst_wr_ready),
        .mst_ar_ready_i (mst_ar_ready),
        .b_done_i       (b_done),
        .r_done_i       (r_done)
    );

    // A full tracker holds back its response channel
    assign b_ready_arb = slv_req_i.b_ready & ~b_full;
    assign r_ready_arb = slv_req_i.r_ready & ~r_full;

    ace_resp_arbiter #(
        .DataWidth_t (b_chan_t)
    ) u_b_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (b_valid_in),
        .data_i      (b_in),
        .ready_o     (b_ready_out),
        .valid_o     (b_valid_arb),
        .data_o      (b_arb),
        .ready_i     (b_ready_arb),
        .grant_idx_o (b_idx)
    );

    ace_resp_arbiter #(
        .DataWidth_t (r_chan_t)
    ) u_r_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (r_valid_in),
        .data_i      (r_in),
        .ready_o     (r_ready_out),
        .valid_o     (r_valid_arb),
        .data_o      (r_arb),
        .ready_i     (r_ready_arb),
        .grant_idx_o (r_idx)
    );

    // Upstream handshakes retire router entries and feed the trackers
    assign b_done = b_valid_arb & b_ready_arb;
    assign r_done = r_valid_arb & r_ready_arb & r_arb.last;

    ace_ack_tracker u_b_tracker (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (b_done),
        .idx_i   (b_idx),
        .ack_i   (slv_req_i.wack),
        .full_o  (b_full),
        .ack_o   (wack)
    );

    ace_ack_tracker u_r_tracker (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (r_done),
        .idx_i   (r_idx),
        .ack_i   (slv_req_i.rack),
        .full_o  (r_full),
        .ack_o   (rack)
    );

    always_comb begin
        slv_resp_o.wr_ready = wr_ready;
        slv_resp_o.ar_ready = ar_ready;
        slv_resp_o.b_valid  = b_valid_arb & ~b_full;
        slv_resp_o.b        = b_arb;
        slv_resp_o.r_valid  = r_valid_arb & ~r_full;
        slv_resp_o.r        = r_arb;
    end

    // Payloads go to every port and only valid qualifies them
    always_comb begin
        for (int unsigned i = 0; i < NoMstPorts; i++) begin
            mst_reqs_o[i].wr_valid = mst_wr_valid[i];
            mst_reqs_o[i].wr       = slv_req_i.wr;
            mst_reqs_o[i].ar_valid = mst_ar_valid[i];
            mst_reqs_o[i].ar       = slv_req_i.ar;
            mst_reqs_o[i].b_ready  = b_ready_out[i];
            mst_reqs_o[i].r_ready  = r_ready_out[i];
            mst_reqs_o[i].wack     = wack[i];
            mst_reqs_o[i].rack     = rack[i];
        end
    end

endmodule

/* hw/ace_ack_tracker.sv */
`timescale 1ns/10ps

module ace_ack_tracker (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                push_i,
    input  ace_cfg_pkg::port_idx_t              idx_i,
    input  logic                                ack_i,
    output logic                                full_o,
    output logic [ace_cfg_pkg::NoMstPorts-1:0]  ack_o
);

    import ace_cfg_pkg::*;

    typedef logic [$clog2(MaxTrans+1)-1:0] cnt_t;

    port_idx_t                     mem_q [MaxTrans];
    logic [$clog2(MaxTrans)-1:0]   wr_ptr_q;
    logic [$clog2(MaxTrans)-1:0]   rd_ptr_q;
    cnt_t                          cnt_q;
    logic                          empty;
    logic                          pop;

    assign full_o = (cnt_q == cnt_t'(MaxTrans));
    assign empty  = (cnt_q == '0);
    assign pop    = ack_i & ~empty;

    // Steer the ack to the port of the oldest response
    always_comb begin
        ack_o                  = '0;
        ack_o[mem_q[rd_ptr_q]] = pop;
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= idx_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_i && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (!push_i && pop) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o);
    a_no_ack_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |-> !empty);

endmodule

/* hw/ace_resp_arbiter.sv */
`timescale 1ns/10ps

module ace_resp_arbiter #(
    parameter type DataWidth_t = logic
) (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic       [ace_cfg_pkg::NoMstPorts-1:0] valid_i,
    input  DataWidth_t [ace_cfg_pkg::NoMstPorts-1:0] data_i,
    output logic       [ace_cfg_pkg::NoMstPorts-1:0] ready_o,
    output logic                                    valid_o,
    output DataWidth_t                              data_o,
    input  logic                                    ready_i,
    output ace_cfg_pkg::port_idx_t                  grant_idx_o
);

    import ace_cfg_pkg::*;

    port_idx_t ptr_q;
    port_idx_t lock_idx_q;
    logic      lock_q;
    port_idx_t rr_idx;
    port_idx_t grant_idx;

    // First requesting port at or after the pointer
    always_comb begin
        port_idx_t cand;
        logic      found;
        rr_idx = ptr_q;
        found  = 1'b0;
        for (int unsigned i = 0; i < NoMstPorts; i++) begin
            cand = ptr_q + port_idx_t'(i);
            if (!found && valid_i[cand]) begin
                rr_idx = cand;
                found  = 1'b1;
            end
        end
    end

    // A stalled grant stays put until its handshake
    assign grant_idx = lock_q ? lock_idx_q : rr_idx;

    assign valid_o     = valid_i[grant_idx];
    assign data_o      = data_i[grant_idx];
    assign grant_idx_o = grant_idx;

    always_comb begin
        ready_o            = '0;
        ready_o[grant_idx] = valid_o & ready_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            if (valid_o && ready_i) begin
                ptr_q  <= grant_idx + 1'b1;
                lock_q <= 1'b0;
            end else if (valid_o) begin
                lock_q     <= 1'b1;
                lock_idx_q <= grant_idx;
            end
        end
    end

    // Relies on the master ports holding their responses
    a_stable_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o)));

    a_grant_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && !ready_i) |=> $stable(grant_idx_o));

endmodule

/* hw/ace_req_router.sv */
`timescale 1ns/10ps

module ace_req_router (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                wr_valid_i,
    input  ace_cfg_pkg::port_idx_t              wr_select_i,
    input  logic                                ar_valid_i,
    input  ace_cfg_pkg::port_idx_t              ar_select_i,
    output logic                                wr_ready_o,
    output logic                                ar_ready_o,
    output logic [ace_cfg_pkg::NoMstPorts-1:0]  mst_wr_valid_o,
    output logic [ace_cfg_pkg::NoMstPorts-1:0]  mst_ar_valid_o,
    input  logic [ace_cfg_pkg::NoMstPorts-1:0]  mst_wr_ready_i,
    input  logic [ace_cfg_pkg::NoMstPorts-1:0]  mst_ar_ready_i,
    input  logic                                b_done_i,
    input  logic                                r_done_i
);

    import ace_cfg_pkg::*;

    typedef logic [$clog2(MaxTrans+1)-1:0] cnt_t;

    // Direction 0 is write, direction 1 is read
    logic            [1:0]                 req_valid;
    port_idx_t       [1:0]                 req_sel;
    logic            [1:0]                 req_ready;
    logic            [1:0]                 done;
    logic            [1:0][NoMstPorts-1:0] mst_valid;
    logic            [1:0][NoMstPorts-1:0] mst_ready;

    assign req_valid = {ar_valid_i, wr_valid_i};
    assign req_sel   = {ar_select_i, wr_select_i};
    assign done      = {r_done_i, b_done_i};
    assign mst_ready = {mst_ar_ready_i, mst_wr_ready_i};

    for (genvar d = 0; d < 2; d++) begin : g_dir
        cnt_t      cnt_q;
        port_idx_t lock_q;
        logic      allow;
        logic      hs;

        // Outstanding traffic pins the direction to one port
        assign allow = (cnt_q == '0) ||
                       ((req_sel[d] == lock_q) && (cnt_q != cnt_t'(MaxTrans)));

        assign mst_valid[d] = (req_valid[d] && allow) ?
                              (NoMstPorts'(1) << req_sel[d]) : '0;
        assign req_ready[d] = allow & mst_ready[d][req_sel[d]];
        assign hs           = req_valid[d] & req_ready[d];

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                cnt_q  <= '0;
                lock_q <= '0;
            end else begin
                if (hs && !done[d]) begin
                    cnt_q <= cnt_q + 1'b1;
                end else if (!hs && done[d]) begin
                    cnt_q <= cnt_q - 1'b1;
                end
                if (hs) begin
                    lock_q <= req_sel[d];
                end
            end
        end

        // Relies on the upstream port holding its request
        a_valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            ((mst_valid[d] != '0) && !hs) |=> $stable(mst_valid[d]));
        a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            done[d] |-> (cnt_q != '0));
    end

    assign wr_ready_o     = req_ready[0];
    assign ar_ready_o     = req_ready[1];
    assign mst_wr_valid_o = mst_valid[0];
    assign mst_ar_valid_o = mst_valid[1];

endmodule

/* hw/ace_chan_pkg.sv */
package ace_chan_pkg;

    import ace_cfg_pkg::*;

    // Write address and data as one single-beat channel
    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data;
    } wr_chan_t;

    typedef struct packed {
        logic [AddrWidth-1:0] addr;
    } ar_chan_t;

    typedef struct packed {
        logic [1:0] resp;
    } b_chan_t;

    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic [1:0]           resp;
        logic                 last;
    } r_chan_t;

    typedef struct packed {
        logic     wr_valid;
        wr_chan_t wr;
        logic     ar_valid;
        ar_chan_t ar;
        logic     b_ready;
        logic     r_ready;
        logic     wack;
        logic     rack;
    } slv_req_t;

    typedef struct packed {
        logic      wr_ready;
        logic      ar_ready;
        logic      b_valid;
        b_chan_t   b;
        logic      r_valid;
        r_chan_t   r;
    } slv_resp_t;

    // Downstream bundles carry the same fields as the upstream ones
    typedef slv_req_t  mst_req_t;
    typedef slv_resp_t mst_resp_t;

endpackage

/* hw/ace_cfg_pkg.sv */
package ace_cfg_pkg;

    // Downstream port count and index width
    localparam int unsigned NoMstPorts   = 4;
    localparam int unsigned PortIdxWidth = $clog2(NoMstPorts);

    // Depth of each ack tracker and outstanding limit per direction
    localparam int unsigned MaxTrans     = 4;

    localparam int unsigned AddrWidth    = 32;
    localparam int unsigned DataWidth    = 32;

    typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage
